/* frontend_cfg.svh */
// frontend sizing macros, included by the package and by any module that needs the reset PC or ROB depth
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// first fetch address after reset
`define FE_RESET_PC 32'h0000_0000

// entries that may be outstanding in the ROB
`define FE_ROB_DEPTH 16

// ROB id width
// wider than log2 of the depth so ids stay unique across a flush
`define FE_ROB_ID_W 7

`endif

/* frontend_pkg.sv */
// shared frontend types, imported by fetch, decode, the ROB id allocator and the top level
`include "frontend_cfg.svh"

package frontend_pkg;

  typedef logic [31:0]               addr_t;
  typedef logic [31:0]               insn_t;
  typedef logic [31:0]               imm_t;
  typedef logic [`FE_ROB_ID_W-1:0]   rob_id_t;
  typedef logic [4:0]                rsop_t;
  typedef logic [6:0]                retop_t;

  // major opcode, instruction bits 6 to 2
  typedef enum logic [4:0] {
    OPC_LOAD,      OPC_LOADFP,    OPC_CUSTOM0,   OPC_MISCMEM,
    OPC_OPIMM,     OPC_AUIPC,     OPC_OPIMM32,   OPC_48B0,
    OPC_STORE,     OPC_STOREFP,   OPC_CUSTOM1,   OPC_AMO,
    OPC_OP,        OPC_LUI,       OPC_OP32,      OPC_64B,
    OPC_MADD,      OPC_MSUB,      OPC_NMSUB,     OPC_NMADD,
    OPC_OPFP,      OPC_RESERVED0, OPC_CUSTOM2,   OPC_48B1,
    OPC_BRANCH,    OPC_JALR,      OPC_RESERVED1, OPC_JAL,
    OPC_SYSTEM,    OPC_RESERVED2, OPC_CUSTOM3,   OPC_80B
  } opcode_e;

  typedef enum logic [1:0] {
    ECAUSE_IALIGN   = 2'd0,
    ECAUSE_IFAULT   = 2'd1,
    ECAUSE_IILLEGAL = 2'd2
  } ecause_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_BUS,
    FETCH_HOLD
  } fetch_state_e;

endpackage

/* insn_fetch.sv */
// Wishbone classic fetch unit, reads one instruction word per bus cycle and holds it for decode
`timescale 1ns/100ps
`include "frontend_cfg.svh"

module insn_fetch (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 flush_i,
  input  frontend_pkg::addr_t  flush_pc_i,
  input  frontend_pkg::insn_t  wb_dat_i,
  input  logic                 wb_ack_i,
  input  logic                 wb_err_i,
  input  logic                 decode_stall,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output frontend_pkg::addr_t  wb_adr_o,
  output logic                 fetch_valid,
  output logic                 fetch_error,
  output frontend_pkg::addr_t  fetch_addr,
  output frontend_pkg::insn_t  fetch_insn
);
  import frontend_pkg::*;

  fetch_state_e state;
  addr_t        pc;
  addr_t        bus_adr;
  insn_t        insn_q;
  logic         err_q;
  logic         discard;
  logic         bus_done;
  logic         taken;

  assign bus_done = wb_ack_i | wb_err_i;
  assign taken    = (state == FETCH_HOLD) & ~decode_stall;

  // cyc and stb always move together
  assign wb_cyc_o = (state == FETCH_BUS);
  assign wb_stb_o = (state == FETCH_BUS);
  assign wb_adr_o = bus_adr;

  assign fetch_valid = (state == FETCH_HOLD);
  assign fetch_error = err_q;
  assign fetch_addr  = bus_adr;
  assign fetch_insn  = insn_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= FETCH_IDLE;
      pc      <= `FE_RESET_PC;
      discard <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (flush_i) begin
            pc <= flush_pc_i;
          end else begin
            state <= FETCH_BUS;
          end
        end
        FETCH_BUS: begin
          // a flushed cycle still has to finish on the bus
          if (bus_done) begin
            discard <= 1'b0;
            state   <= (discard | flush_i) ? FETCH_IDLE : FETCH_HOLD;
          end else if (flush_i) begin
            discard <= 1'b1;
          end
          if (flush_i) begin
            pc <= flush_pc_i;
          end
        end
        FETCH_HOLD: begin
          if (flush_i) begin
            pc    <= flush_pc_i;
            state <= FETCH_IDLE;
          end else if (taken) begin
            pc    <= pc + 32'd4;
            state <= FETCH_IDLE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // address stays put for the whole bus cycle
  always_ff @(posedge clk) begin
    if (state == FETCH_IDLE && !flush_i) begin
      bus_adr <= pc;
    end
    if (state == FETCH_BUS && bus_done) begin
      insn_q <= wb_dat_i;
      err_q  <= wb_err_i;
    end
  end

endmodule

/* insn_decode.sv */
// RV32I decode stage, registers a fetched word and drives the rename and ROB ports from it
`timescale 1ns/100ps

module insn_decode (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   flush_i,
  input  logic                   fetch_valid,
  input  logic                   fetch_error,
  input  frontend_pkg::addr_t    fetch_addr,
  input  frontend_pkg::insn_t    fetch_insn,
  input  logic                   rob_full,
  input  frontend_pkg::rob_id_t  robid,
  input  logic                   rename_stall_i,
  output logic                   decode_stall,
  output logic                   alloc,
  output logic                   decode_rob_valid_o,
  output logic                   decode_error_o,
  output frontend_pkg::ecause_e  decode_ecause_o,
  output frontend_pkg::retop_t   decode_retop_o,
  output logic [5:0]             decode_rd_o,
  output frontend_pkg::addr_t    decode_addr_o,
  output frontend_pkg::addr_t    decode_target_o,
  output frontend_pkg::rob_id_t  decode_robid_o,
  output logic                   decode_rename_valid_o,
  output frontend_pkg::rsop_t    decode_rsop_o,
  output logic                   decode_uses_rs1_o,
  output logic                   decode_uses_rs2_o,
  output logic                   decode_uses_imm_o,
  output logic                   decode_uses_memory_o,
  output logic                   decode_uses_pc_o,
  output logic                   decode_csr_access_o,
  output logic [4:0]             decode_rs1_o,
  output logic [4:0]             decode_rs2_o,
  output frontend_pkg::imm_t     decode_imm_o
);
  import frontend_pkg::*;

  logic       valid_q;
  logic       error_q;
  addr_t      addr_q;
  insn_t      insn_q;

  logic       fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_inv;
  imm_t       imm;
  rsop_t      rsop;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [4:0] rd;
  logic [2:0] brop;
  logic       insn_load, insn_jalr, insn_auipc, insn_opimm, insn_csr;
  logic       insn_complex, altop;
  logic       uses_rd, uses_memory;

  assign opcode = opcode_e'(insn_q[6:2]);
  assign funct3 = insn_q[14:12];
  assign rd     = insn_q[11:7];

  assign insn_load    = (opcode == OPC_LOAD);
  assign insn_jalr    = (opcode == OPC_JALR);
  assign insn_auipc   = (opcode == OPC_AUIPC);
  assign insn_opimm   = (opcode == OPC_OPIMM);
  assign insn_csr     = (opcode == OPC_SYSTEM) & (funct3[1:0] != 2'b00);
  assign insn_complex = fmt_r & insn_q[25];

  // SUB, SRA and SRAI use the alternate op
  assign altop = (fmt_r | (insn_opimm & (funct3 == 3'b101))) & insn_q[30];
  assign brop  = {~|funct3[2:1], funct3[2:1]};

  assign uses_rd     = (fmt_r | fmt_i | fmt_u | fmt_j) & (rd != 5'd0);
  assign uses_memory = insn_load | fmt_s;

  // handshakes
  assign decode_stall          = rob_full | rename_stall_i;
  assign alloc                 = valid_q & ~decode_stall;
  assign decode_rob_valid_o    = valid_q & ~rename_stall_i;
  assign decode_rename_valid_o = valid_q & ~decode_error_o & ~rob_full;

  assign decode_error_o  = error_q | fmt_inv;
  assign decode_ecause_o = error_q ? ((addr_q[1:0] != 2'b00) ? ECAUSE_IALIGN : ECAUSE_IFAULT)
                                   : ECAUSE_IILLEGAL;
  assign decode_retop_o  = {fmt_b, funct3[0], insn_jalr, fmt_s, funct3};
  assign decode_rd_o     = {~uses_rd, rd};
  assign decode_addr_o   = addr_q;
  // JALR target is resolved later, so carry the link address
  assign decode_target_o = addr_q + (insn_jalr ? 32'd4 : imm);
  assign decode_robid_o  = robid;

  assign decode_rsop_o        = rsop;
  assign decode_uses_rs1_o    = fmt_r | (fmt_i & (~insn_csr | ~funct3[2])) | fmt_s | fmt_b;
  assign decode_uses_rs2_o    = fmt_r | fmt_s | fmt_b;
  assign decode_uses_imm_o    = ~fmt_r & ~fmt_b;
  assign decode_uses_memory_o = uses_memory;
  assign decode_uses_pc_o     = fmt_j | insn_auipc;
  assign decode_csr_access_o  = insn_csr;
  assign decode_rs1_o         = insn_q[19:15];
  assign decode_rs2_o         = insn_q[24:20];
  assign decode_imm_o         = fmt_j ? 32'd4 : imm;

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (!decode_stall) begin
      valid_q <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!decode_stall && fetch_valid) begin
      error_q <= fetch_error;
      addr_q  <= fetch_addr;
      insn_q  <= fetch_insn;
    end
  end

  // format decoder, compressed words are illegal
  always_comb begin
    {fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_inv} = 7'b0;
    if (insn_q[1:0] != 2'b11) begin
      fmt_inv = 1'b1;
    end else begin
      case (opcode)
        OPC_OP:      fmt_r = 1'b1;
        OPC_OPIMM:   fmt_i = 1'b1;
        OPC_LUI:     fmt_u = 1'b1;
        OPC_AUIPC:   fmt_u = 1'b1;
        OPC_LOAD:    fmt_i = 1'b1;
        OPC_STORE:   fmt_s = 1'b1;
        OPC_BRANCH:  fmt_b = 1'b1;
        OPC_JAL:     fmt_j = 1'b1;
        OPC_JALR:    fmt_i = 1'b1;
        OPC_MISCMEM: fmt_i = 1'b1;
        OPC_SYSTEM:  fmt_i = 1'b1;
        default:     fmt_inv = 1'b1;
      endcase
    end
  end

  always_comb begin
    case (1'b1)
      fmt_i:   imm = {{20{insn_q[31]}}, insn_q[31:20]};
      fmt_s:   imm = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
      fmt_b:   imm = {{20{insn_q[31]}}, insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};
      fmt_u:   imm = {insn_q[31:12], 12'b0};
      fmt_j:   imm = {{12{insn_q[31]}}, insn_q[19:12], insn_q[20], insn_q[30:21], 1'b0};
      default: imm = 32'd0;
    endcase
  end

  always_comb begin
    case (1'b1)
      uses_memory:                 rsop = {1'b0, fmt_s, funct3};
      fmt_j, insn_jalr, fmt_u:     rsop = 5'b00000;
      fmt_b:                       rsop = {2'b01, brop};
      default:                     rsop = {insn_complex, insn_complex | altop, funct3};
    endcase
  end

endmodule

/* rob_id_alloc.sv */
// ROB id allocator, hands out sequential ids and flags when the ROB has no free entry
`timescale 1ns/100ps
`include "frontend_cfg.svh"

module rob_id_alloc (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   flush_i,
  input  logic                   alloc,
  input  logic                   retire_i,
  output frontend_pkg::rob_id_t  robid,
  output logic                   rob_full
);

  localparam int unsigned CNT_W = $clog2(`FE_ROB_DEPTH + 1);

  logic [CNT_W-1:0] count;

  assign rob_full = (count == CNT_W'(`FE_ROB_DEPTH));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      robid <= '0;
      count <= '0;
    end else begin
      // ids keep running across a flush
      if (alloc) begin
        robid <= robid + 1'b1;
      end
      if (flush_i) begin
        count <= '0;
      end else if (alloc && !retire_i) begin
        count <= count + 1'b1;
      end else if (!alloc && retire_i && count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* frontend_top.sv */
// frontend top level, joins fetch, decode and the ROB id allocator for the testbench
`timescale 1ns/100ps

module frontend_top (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   flush_i,
  input  frontend_pkg::addr_t    flush_pc_i,
  input  logic                   retire_i,
  input  logic                   rename_stall_i,
  input  frontend_pkg::insn_t    wb_dat_i,
  input  logic                   wb_ack_i,
  input  logic                   wb_err_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output frontend_pkg::addr_t    wb_adr_o,
  output logic                   decode_rob_valid_o,
  output logic                   decode_error_o,
  output frontend_pkg::ecause_e  decode_ecause_o,
  output frontend_pkg::retop_t   decode_retop_o,
  output logic [5:0]             decode_rd_o,
  output frontend_pkg::addr_t    decode_addr_o,
  output frontend_pkg::addr_t    decode_target_o,
  output frontend_pkg::rob_id_t  decode_robid_o,
  output logic                   decode_rename_valid_o,
  output frontend_pkg::rsop_t    decode_rsop_o,
  output logic                   decode_uses_rs1_o,
  output logic                   decode_uses_rs2_o,
  output logic                   decode_uses_imm_o,
  output logic                   decode_uses_memory_o,
  output logic                   decode_uses_pc_o,
  output logic                   decode_csr_access_o,
  output logic [4:0]             decode_rs1_o,
  output logic [4:0]             decode_rs2_o,
  output frontend_pkg::imm_t     decode_imm_o
);
  import frontend_pkg::*;

  // fetch to decode
  logic    fetch_valid;
  logic    fetch_error;
  addr_t   fetch_addr;
  insn_t   fetch_insn;
  logic    decode_stall;

  // decode to allocator
  logic    alloc;
  rob_id_t robid;
  logic    rob_full;

  insn_fetch i_insn_fetch (.*);

  insn_decode i_insn_decode (.*);

  rob_id_alloc i_rob_id_alloc (.*);

endmodule

/* tb_frontend.sv */
// replays the golden instruction list through frontend_top and checks every decode result
`timescale 1ns/100ps

module tb_frontend;
  logic clk, reset_i, flush_i, retire_i, rename_stall_i, wb_ack_i, wb_err_i;
  logic [31:0] flush_pc_i, wb_dat_i, wb_adr_o, decode_addr_o, decode_target_o, decode_imm_o;
  logic wb_cyc_o, wb_stb_o, decode_rob_valid_o, decode_error_o, decode_rename_valid_o;
  logic [1:0] decode_ecause_o;
  logic [6:0] decode_retop_o, decode_robid_o;
  logic [5:0] decode_rd_o;
  logic [4:0] decode_rsop_o, decode_rs1_o, decode_rs2_o;
  logic decode_uses_rs1_o, decode_uses_rs2_o, decode_uses_imm_o;
  logic decode_uses_memory_o, decode_uses_pc_o, decode_csr_access_o;

  logic [175:0] gold [0:14];
  logic [6:0] exp_retop [0:14];
  integer seed, err_count, test_err, wait_cnt;
  logic timed_out, stall_rand, ack_rand, retire_rand;
  logic [31:0] err_addr;
  logic [6:0] exp_id;

  frontend_top i_frontend_top (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (a[31:2] < 15) return gold[a[31:2]][143:112];
    // ADDI x0 with an immediate folded from the address
    return {a[11:0] ^ a[23:12] ^ {4'd0, a[31:24]}, 20'h00013};
  endfunction

  // slave answers after 0 to 3 wait states and raises err at one chosen address
  always @(negedge clk) begin
    if (reset_i || wb_ack_i || wb_err_i) begin
      wb_ack_i = 1'b0;
      wb_err_i = 1'b0;
      wait_cnt = ack_rand ? ($random(seed) & 3) : 0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (wait_cnt == 0) begin
        wb_dat_i = mem_word(wb_adr_o);
        if (wb_adr_o == err_addr) wb_err_i = 1'b1;
        else wb_ack_i = 1'b1;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      err_count = err_count + 1;
    end
  endtask

  // drive on the falling edge and sample once outputs settle
  task automatic next_cycle();
    @(negedge clk);
    flush_i = 1'b0;
    rename_stall_i = stall_rand ? $random(seed) & 1 : 1'b0;
    retire_i = retire_rand ? (($random(seed) & 3) == 0) : 1'b0;
    #1;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset_i = 1'b1;
    {stall_rand, ack_rand, retire_rand} = 3'b000;
    {flush_i, retire_i, rename_stall_i} = 3'b000;
    err_addr = 32'hffff_ffff;
    repeat (4) @(negedge clk);
    reset_i = 1'b0;
    exp_id = 7'd0;
  endtask

  task automatic wait_accept(input logic strict);
    integer n;
    n = 0;
    if (!timed_out) begin
      next_cycle();
      while (!(decode_rob_valid_o && (!strict || decode_rename_valid_o)) && n < 200) begin
        next_cycle();
        n = n + 1;
      end
      if (n >= 200) begin
        $display("timeout at %0t, no instruction was accepted by decode", $time);
        timed_out = 1'b1;
        err_count = err_count + 1;
      end
    end
  endtask

  task automatic check_entry(input integer i);
    logic [175:0] g;
    g = gold[i];
    check_val("decode_addr_o", g[175:144], decode_addr_o);
    if (g[7:4] == 0) begin
      check_val("decode_rsop_o", g[111:104], decode_rsop_o);
      check_val("decode_rs1_o", g[103:96], decode_rs1_o);
      check_val("decode_rs2_o", g[95:88], decode_rs2_o);
      check_val("decode_rd_o", g[87:80], decode_rd_o);
      check_val("decode_imm_o", g[79:48], decode_imm_o);
      check_val("decode_target_o", g[47:16], decode_target_o);
      check_val("flags", g[15:8], {decode_uses_rs1_o, decode_uses_rs2_o, decode_uses_imm_o,
                                   decode_uses_memory_o, decode_uses_pc_o, decode_csr_access_o});
      check_val("decode_retop_o", exp_retop[i], decode_retop_o);
      check_val("decode_error_o", 0, decode_error_o);
      check_val("decode_rename_valid_o", 1, decode_rename_valid_o);
    end else begin
      check_val("decode_error_o", 1, decode_error_o);
      check_val("decode_ecause_o", g[3:0], decode_ecause_o);
      check_val("decode_rename_valid_o", 0, decode_rename_valid_o);
    end
  endtask

  task automatic run_sequence(input integer first, input integer last, input logic strict,
                              input logic check_id);
    for (int i = first; i <= last; i++) begin
      wait_accept(strict);
      if (!timed_out) begin
        check_entry(i);
        if (check_id) check_val("decode_robid_o", exp_id, decode_robid_o);
        exp_id = exp_id + 7'd1;
      end
    end
  endtask

  task automatic report_test(input string name);
    $display("%s finished with %0d errors", name, err_count - test_err);
    test_err = err_count;
  endtask

  initial begin
    integer n_acc;
    seed = 32'h3a85_5acc;
    {err_count, test_err, wait_cnt} = 0;
    timed_out = 1'b0;
    {reset_i, flush_i, retire_i, rename_stall_i, wb_ack_i, wb_err_i} = 6'b100000;
    {stall_rand, ack_rand, retire_rand} = 3'b000;
    flush_pc_i = 32'd0;
    wb_dat_i = 32'd0;
    err_addr = 32'hffff_ffff;
    $readmemh("frontend_golden.txt", gold);
    // expected retire opcode for each golden entry
    exp_retop = '{7'h00, 7'h00, 7'h25, 7'h02, 7'h0a, 7'h40, 7'h00, 7'h10,
                  7'h25, 7'h21, 7'h21, 7'h00, 7'h00, 7'h00, 7'h00};

    apply_reset();
    run_sequence(0, 10, 1'b0, 1'b1);
    report_test("test 1 in-order decode");
    run_sequence(11, 14, 1'b0, 1'b1);
    report_test("test 2 illegal instructions");

    apply_reset();
    {stall_rand, ack_rand, retire_rand} = 3'b111;
    run_sequence(0, 10, 1'b1, 1'b1);
    report_test("test 3 back-pressure");

    // start in the nop region so every word needs a rename slot
    apply_reset();
    @(negedge clk);
    flush_i = 1'b1;
    flush_pc_i = 32'h38;
    n_acc = 0;
    for (int c = 0; c < 120; c++) begin
      next_cycle();
      if (decode_rob_valid_o && decode_rename_valid_o) n_acc = n_acc + 1;
    end
    check_val("accepted before retire", 16, n_acc);
    @(negedge clk);
    retire_i = 1'b1;
    n_acc = 0;
    for (int c = 0; c < 40; c++) begin
      next_cycle();
      if (decode_rob_valid_o && decode_rename_valid_o) n_acc = n_acc + 1;
    end
    check_val("accepted after retire", 1, n_acc);
    report_test("test 4 ROB full");

    apply_reset();
    ack_rand = 1'b1;
    run_sequence(0, 1, 1'b0, 1'b0);
    @(negedge clk);
    flush_i = 1'b1;
    flush_pc_i = gold[5][175:144];
    run_sequence(5, 6, 1'b0, 1'b0);
    report_test("test 5 flush");

    apply_reset();
    err_addr = gold[3][175:144];
    run_sequence(0, 2, 1'b0, 1'b1);
    wait_accept(1'b0);
    if (!timed_out) begin
      check_val("decode_addr_o", err_addr, decode_addr_o);
      check_val("decode_error_o", 1, decode_error_o);
      check_val("decode_ecause_o", 1, decode_ecause_o);
      check_val("decode_rename_valid_o", 0, decode_rename_valid_o);
    end
    report_test("test 6 bus error");

    $display("6 tests run, %0d errors", err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+.
frontend_pkg.sv
insn_fetch.sv
insn_decode.sv
rob_id_alloc.sv
frontend_top.sv
tb_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the frontend testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_frontend -f files.f \
  -o tb_frontend_sim > sim.log 2>&1 &&
./obj_dir/tb_frontend_sim >> sim.log 2>&1 ||
{ echo "build or simulation did not complete, see sim.log"; exit 1; }
grep -q "Checks failed" sim.log &&
{ echo "FAIL"; exit 1; } ||
{ echo "PASS"; exit 0; }

/* frontend_golden.txt */
// addr_word_rsop_rs1_rs2_rd_imm_target_flags_error_cause
// flags bits 5..0 are uses rs1, rs2, imm, memory, pc and csr access
00000000_002081b3_00_01_02_03_00000000_00000000_30_0_2
00000004_40118233_08_03_01_04_00000000_00000004_30_0_2
00000008_40325293_0d_04_03_05_00000403_0000040b_28_0_2
0000000c_0080a303_02_01_08_06_00000008_00000014_2c_0_2
00000010_00612623_0a_02_06_2c_0000000c_0000001c_3c_0_2
00000014_00208863_0c_01_02_30_00000010_00000024_30_0_2
00000018_008000ef_00_00_08_01_00000004_00000020_0a_0_2
0000001c_00008067_00_01_00_20_00000000_00000020_28_0_2
00000020_123453b7_00_08_03_07_12345000_12345020_08_0_2
00000024_00001417_00_00_00_08_00001000_00001024_0a_0_2
00000028_300514f3_01_0a_00_09_00000300_00000328_29_0_2
0000002c_00000001_00_00_00_00_00000000_00000000_00_1_2
00000030_0021a0af_00_00_00_00_00000000_00000000_00_1_2
00000034_003100d3_00_00_00_00_00000000_00000000_00_1_2
00000038_00000013_00_00_00_20_00000000_00000038_28_0_2
